// ==== include/conv_defs.svh ====
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// widths of the datapath
`define CONV_DATA_W 16
`define CONV_ACC_W 32

// geometry of the layer
`define CONV_IFM_SIZE 8
`define CONV_KERNEL 3
`define CONV_TAPS 9
`define CONV_CHANNELS 3
`define CONV_FILTERS 2

// no padding and stride 1, so the output side is IFM_SIZE - KERNEL + 1
`define CONV_OFM_SIZE 6

// host address word, decoded per region
`define CONV_ADDR_W 8

`endif

// ==== hw/conv_pkg.sv ====
`default_nettype none

`include "conv_defs.svh"

package conv_pkg;

    typedef enum logic [1:0] {
        REGION_IFM  = 2'd0,
        REGION_WGT  = 2'd1,
        REGION_BIAS = 2'd2
    } host_region_t;

    typedef struct packed {
        logic [1:0] channel;
        logic [2:0] row;
        logic [2:0] col;
    } ifm_addr_t;

    // the bias region reuses this layout and reads only the filter field
    typedef struct packed {
        logic       spare;
        logic       filter;
        logic [1:0] channel;
        logic [3:0] tap;
    } wgt_addr_t;

    typedef union packed {
        ifm_addr_t              ifm;
        wgt_addr_t              wgt;
        logic [`CONV_ADDR_W-1:0] raw;
    } host_addr_u;

    typedef struct packed {
        host_region_t                   region;
        host_addr_u                     addr;
        logic signed [`CONV_DATA_W-1:0] data;
    } host_wr_t;

    typedef struct packed {
        logic       filter;
        logic [2:0] row;
        logic [2:0] col;
        logic [3:0] tap;
        logic       first;
        logic       last;
    } tap_ctrl_t;

    typedef struct packed {
        logic                           filter;
        logic [2:0]                     row;
        logic [2:0]                     col;
        logic signed [`CONV_DATA_W-1:0] value;
    } result_t;

endpackage

`default_nettype wire

// ==== hw/feature_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module feature_bank (
    input  wire logic                           clk,
    input  wire conv_pkg::host_wr_t             host_wr,
    input  wire logic                           host_wr_valid,
    input  wire conv_pkg::tap_ctrl_t            tap,
    input  wire logic                           tap_valid,
    input  wire logic [1:0]                     channel_id,
    output      logic signed [`CONV_DATA_W-1:0] pixel
);
    import conv_pkg::*;

    logic signed [`CONV_DATA_W-1:0] mem [`CONV_IFM_SIZE * `CONV_IFM_SIZE];

    logic       wr_en;
    logic [3:0] k_row;
    logic [3:0] k_col;
    logic [2:0] rd_row;
    logic [2:0] rd_col;

    assign wr_en = host_wr_valid && (host_wr.region == REGION_IFM) &&
                   (host_wr.addr.ifm.channel == channel_id);

    // tap index is row-major inside the kernel
    assign k_row = tap.tap / 4'(`CONV_KERNEL);
    assign k_col = tap.tap % 4'(`CONV_KERNEL);

    // the window never leaves the map, so the 3-bit sums cannot wrap
    assign rd_row = tap.row + k_row[2:0];
    assign rd_col = tap.col + k_col[2:0];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[{host_wr.addr.ifm.row, host_wr.addr.ifm.col}] <= host_wr.data;
        end
        if (tap_valid)
        begin
            pixel <= mem[{rd_row, rd_col}];
        end
    end

endmodule

`default_nettype wire

// ==== hw/channel_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module channel_mac (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire conv_pkg::host_wr_t             host_wr,
    input  wire logic                           host_wr_valid,
    input  wire logic [1:0]                     channel_id,
    input  wire conv_pkg::tap_ctrl_t            tap,
    input  wire logic                           tap_valid,
    input  wire logic signed [`CONV_DATA_W-1:0] pixel,
    output      logic signed [`CONV_ACC_W-1:0]  sum,
    output      conv_pkg::result_t              sum_pos,
    output      logic                           mac_valid
);
    import conv_pkg::*;

    logic signed [`CONV_DATA_W-1:0] wgt_mem [`CONV_FILTERS][`CONV_TAPS];

    logic                           wr_en;
    logic signed [`CONV_DATA_W-1:0] weight;
    tap_ctrl_t                      tap_d;
    logic                           tap_d_valid;
    logic signed [`CONV_ACC_W-1:0]  product;

    assign wr_en = host_wr_valid && (host_wr.region == REGION_WGT) &&
                   (host_wr.addr.wgt.channel == channel_id) &&
                   (host_wr.addr.wgt.tap < 4'(`CONV_TAPS));

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            wgt_mem[host_wr.addr.wgt.filter][host_wr.addr.wgt.tap] <= host_wr.data;
        end
        // weight lands in the same cycle as the pixel from the bank
        if (tap_valid)
        begin
            weight <= wgt_mem[tap.filter][tap.tap];
        end
        tap_d <= tap;
    end

    assign product = pixel * weight;

    always_ff @(posedge clk)
    begin
        if (tap_d_valid)
        begin
            sum <= tap_d.first ? product : sum + product;
        end
        if (tap_d_valid && tap_d.last)
        begin
            sum_pos.filter <= tap_d.filter;
            sum_pos.row    <= tap_d.row;
            sum_pos.col    <= tap_d.col;
            sum_pos.value  <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tap_d_valid <= 1'b0;
            mac_valid   <= 1'b0;
        end
        else
        begin
            tap_d_valid <= tap_valid;
            mac_valid   <= tap_d_valid && tap_d.last;
        end
    end

    // a window is nine back-to-back taps, so its first tap sits eight cycles before last
    assert property (@(posedge clk) disable iff (rst)
        tap_d_valid && tap_d.last |->
            $past(tap_d_valid && tap_d.first, `CONV_TAPS - 1))
        else $error("channel_mac: last tap without a matching first tap");

endmodule

`default_nettype wire

// ==== hw/window_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module window_sequencer (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         start,
    output conv_pkg::tap_ctrl_t tap,
    output      logic         tap_valid,
    output      logic         done
);

    logic       busy;
    logic       filt_cnt;
    logic [2:0] row_cnt;
    logic [2:0] col_cnt;
    logic [3:0] tap_cnt;

    logic tap_end;
    logic col_end;
    logic row_end;
    logic filt_end;

    assign tap_end  = tap_cnt == 4'(`CONV_TAPS - 1);
    assign col_end  = col_cnt == 3'(`CONV_OFM_SIZE - 1);
    assign row_end  = row_cnt == 3'(`CONV_OFM_SIZE - 1);
    assign filt_end = filt_cnt == 1'(`CONV_FILTERS - 1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy     <= 1'b0;
            done     <= 1'b0;
            filt_cnt <= 1'b0;
            row_cnt  <= '0;
            col_cnt  <= '0;
            tap_cnt  <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                // a start while busy never reaches this branch
                if (start)
                begin
                    busy     <= 1'b1;
                    filt_cnt <= 1'b0;
                    row_cnt  <= '0;
                    col_cnt  <= '0;
                    tap_cnt  <= '0;
                end
            end
            else
            begin
                tap_cnt <= tap_end ? 4'd0 : tap_cnt + 4'd1;
                if (tap_end)
                begin
                    col_cnt <= col_end ? 3'd0 : col_cnt + 3'd1;
                    if (col_end)
                    begin
                        row_cnt <= row_end ? 3'd0 : row_cnt + 3'd1;
                        if (row_end)
                        begin
                            filt_cnt <= filt_end ? 1'b0 : filt_cnt + 1'b1;
                            if (filt_end)
                            begin
                                busy <= 1'b0;
                                done <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    assign tap_valid = busy;

    always_comb
    begin
        tap.filter = filt_cnt;
        tap.row    = row_cnt;
        tap.col    = col_cnt;
        tap.tap    = tap_cnt;
        tap.first  = tap_cnt == 4'd0;
        tap.last   = tap_end;
    end

    // the window must stay inside the map so the bank's 3-bit address sums never wrap
    assert property (@(posedge clk) disable iff (rst)
        tap_valid |-> tap.tap < 4'(`CONV_TAPS) &&
            tap.row < 3'(`CONV_OFM_SIZE) && tap.col < 3'(`CONV_OFM_SIZE))
        else $error("window_sequencer: tap outside the window or the output map");

endmodule

`default_nettype wire

// ==== hw/sum_relu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module sum_relu (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire conv_pkg::host_wr_t            host_wr,
    input  wire logic                          host_wr_valid,
    input  wire logic signed [`CONV_ACC_W-1:0] sum0,
    input  wire logic signed [`CONV_ACC_W-1:0] sum1,
    input  wire logic signed [`CONV_ACC_W-1:0] sum2,
    input  wire conv_pkg::result_t             sum_pos,
    input  wire logic                          mac_valid,
    output      conv_pkg::result_t             result,
    output      logic                          result_valid
);
    import conv_pkg::*;

    localparam logic signed [`CONV_ACC_W-1:0] clip_max = (1 <<< (`CONV_DATA_W - 1)) - 1;

    logic signed [`CONV_DATA_W-1:0] bias_mem [`CONV_FILTERS];

    logic signed [`CONV_DATA_W-1:0] bias;
    logic signed [`CONV_ACC_W-1:0]  psum_a;
    logic signed [`CONV_ACC_W-1:0]  psum_b;
    logic signed [`CONV_ACC_W-1:0]  full_sum;
    logic signed [`CONV_DATA_W-1:0] clipped;
    result_t                        pos1;
    logic                           valid1;

    always_ff @(posedge clk)
    begin
        if (host_wr_valid && (host_wr.region == REGION_BIAS))
        begin
            bias_mem[host_wr.addr.wgt.filter] <= host_wr.data;
        end
    end

    assign bias = bias_mem[sum_pos.filter];

    // stage one registers two partial sums
    always_ff @(posedge clk)
    begin
        if (mac_valid)
        begin
            psum_a <= sum0 + sum1;
            psum_b <= sum2 + bias;
            pos1   <= sum_pos;
        end
    end

    assign full_sum = psum_a + psum_b;

    always_comb
    begin
        if (full_sum < 0)
            clipped = '0;
        else if (full_sum > clip_max)
            clipped = clip_max[`CONV_DATA_W-1:0];
        else
            clipped = full_sum[`CONV_DATA_W-1:0];
    end

    // stage two applies ReLU and the clip and registers the result with its position
    always_ff @(posedge clk)
    begin
        if (valid1)
        begin
            result.filter <= pos1.filter;
            result.row    <= pos1.row;
            result.col    <= pos1.col;
            result.value  <= clipped;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid1       <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            valid1       <= mac_valid;
            result_valid <= valid1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        result_valid |-> !result.value[`CONV_DATA_W-1])
        else $error("sum_relu: negative result value");

endmodule

`default_nettype wire

// ==== hw/conv_layer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_layer_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire conv_pkg::host_wr_t host_wr,
    input  wire logic              host_wr_valid,
    input  wire logic              start,
    output      conv_pkg::result_t result,
    output      logic              result_valid,
    output      logic              done
);
    import conv_pkg::*;

    tap_ctrl_t tap;
    logic      tap_valid;

    logic signed [`CONV_DATA_W-1:0] pixel     [`CONV_CHANNELS];
    logic signed [`CONV_ACC_W-1:0]  mac_sum   [`CONV_CHANNELS];
    result_t                        mac_pos   [`CONV_CHANNELS];
    logic                           mac_valid [`CONV_CHANNELS];

    window_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .tap       (tap),
        .tap_valid (tap_valid),
        .done      (done)
    );

    for (genvar ch = 0; ch < `CONV_CHANNELS; ch++)
    begin : g_chan
        feature_bank u_bank (
            .clk           (clk),
            .host_wr       (host_wr),
            .host_wr_valid (host_wr_valid),
            .tap           (tap),
            .tap_valid     (tap_valid),
            .channel_id    (2'(ch)),
            .pixel         (pixel[ch])
        );

        channel_mac u_mac (
            .clk           (clk),
            .rst           (rst),
            .host_wr       (host_wr),
            .host_wr_valid (host_wr_valid),
            .channel_id    (2'(ch)),
            .tap           (tap),
            .tap_valid     (tap_valid),
            .pixel         (pixel[ch]),
            .sum           (mac_sum[ch]),
            .sum_pos       (mac_pos[ch]),
            .mac_valid     (mac_valid[ch])
        );
    end

    // all units run in lockstep, so unit 0 speaks for the window position
    sum_relu u_sum (
        .clk           (clk),
        .rst           (rst),
        .host_wr       (host_wr),
        .host_wr_valid (host_wr_valid),
        .sum0          (mac_sum[0]),
        .sum1          (mac_sum[1]),
        .sum2          (mac_sum[2]),
        .sum_pos       (mac_pos[0]),
        .mac_valid     (mac_valid[0]),
        .result        (result),
        .result_valid  (result_valid)
    );

endmodule

`default_nettype wire

// ==== test/conv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_tb;
    import conv_pkg::*;

    localparam int n_results = `CONV_FILTERS * `CONV_OFM_SIZE * `CONV_OFM_SIZE;
    localparam int run_timeout = n_results * `CONV_TAPS + 100;
    localparam int max_out = (1 << (`CONV_DATA_W - 1)) - 1;

    logic     clk;
    logic     rst;
    host_wr_t host_wr;
    logic     host_wr_valid;
    logic     start;
    result_t  result;
    logic     result_valid;
    logic     done;

    // reference copies of everything loaded into the DUT
    int ifm [`CONV_CHANNELS][`CONV_IFM_SIZE][`CONV_IFM_SIZE];
    int wgt [`CONV_FILTERS][`CONV_CHANNELS][`CONV_TAPS];
    int bias_ref [`CONV_FILTERS];

    result_t exp_q [$];
    result_t exp_front;
    logic    exp_avail;
    bit      started;
    int      result_cnt;
    int      done_cnt;
    int      err_cnt;
    int      tests_run;
    int      tests_failed;

    conv_layer_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .host_wr       (host_wr),
        .host_wr_valid (host_wr_valid),
        .start         (start),
        .result        (result),
        .result_valid  (result_valid),
        .done          (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!rst && result_valid)
        begin
            result_cnt++;
            if (exp_q.size() > 0)
                void'(exp_q.pop_front());
        end
        if (!rst && done)
            done_cnt++;
    end

    // the front of the queue only moves on the falling edge
    always @(negedge clk)
    begin
        exp_avail = exp_q.size() > 0;
        if (exp_avail)
            exp_front = exp_q[0];
    end

    assert property (@(posedge clk) disable iff (rst)
        result_valid && exp_avail |-> result == exp_front)
    else
    begin
        err_cnt++;
        $display("MISMATCH result expected %h got %h", $sampled(exp_front), $sampled(result));
    end

    assert property (@(posedge clk) disable iff (rst) result_valid |-> exp_avail)
    else
    begin
        err_cnt++;
        $display("a result arrived when no result was expected");
    end

    assert property (@(posedge clk) disable iff (rst) !started |-> !result_valid && !done)
    else
    begin
        err_cnt++;
        $display("result_valid or done went high before the first start");
    end

    task automatic host_write(input host_region_t region, input host_addr_u addr, input int data);
        @(negedge clk);
        host_wr.region = region;
        host_wr.addr   = addr;
        host_wr.data   = 16'(data);
        host_wr_valid  = 1'b1;
        @(negedge clk);
        host_wr_valid  = 1'b0;
    endtask

    // every value is drawn from lo to hi inclusive
    task automatic load_layer(input int d_lo, input int d_hi, input int w_lo, input int w_hi,
                              input int b_lo, input int b_hi);
        host_addr_u a;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++)
            for (int r = 0; r < `CONV_IFM_SIZE; r++)
                for (int c = 0; c < `CONV_IFM_SIZE; c++)
                begin
                    ifm[ch][r][c] = d_lo + int'($urandom_range(d_hi - d_lo));
                    a.ifm.channel = 2'(ch);
                    a.ifm.row = 3'(r);
                    a.ifm.col = 3'(c);
                    host_write(REGION_IFM, a, ifm[ch][r][c]);
                end
        for (int f = 0; f < `CONV_FILTERS; f++)
            for (int ch = 0; ch < `CONV_CHANNELS; ch++)
                for (int t = 0; t < `CONV_TAPS; t++)
                begin
                    wgt[f][ch][t] = w_lo + int'($urandom_range(w_hi - w_lo));
                    a.wgt.spare = 1'b0;
                    a.wgt.filter = 1'(f);
                    a.wgt.channel = 2'(ch);
                    a.wgt.tap = 4'(t);
                    host_write(REGION_WGT, a, wgt[f][ch][t]);
                end
        for (int f = 0; f < `CONV_FILTERS; f++)
        begin
            bias_ref[f] = b_lo + int'($urandom_range(b_hi - b_lo));
            a = '0;
            a.wgt.filter = 1'(f);
            host_write(REGION_BIAS, a, bias_ref[f]);
        end
    endtask

    task automatic build_expected();
        longint  acc;
        result_t r;
        for (int f = 0; f < `CONV_FILTERS; f++)
            for (int row = 0; row < `CONV_OFM_SIZE; row++)
                for (int col = 0; col < `CONV_OFM_SIZE; col++)
                begin
                    acc = bias_ref[f];
                    for (int ch = 0; ch < `CONV_CHANNELS; ch++)
                        for (int t = 0; t < `CONV_TAPS; t++)
                            acc += longint'(ifm[ch][row + t / `CONV_KERNEL][col + t % `CONV_KERNEL])
                                   * wgt[f][ch][t];
                    r.filter = 1'(f);
                    r.row = 3'(row);
                    r.col = 3'(col);
                    if (acc < 0)
                        r.value = '0;
                    else if (acc > max_out)
                        r.value = 16'(max_out);
                    else
                        r.value = 16'(acc);
                    exp_q.push_back(r);
                end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, err_cnt - err_before);
        end
    endtask

    task automatic run_layer(input string name, input bit restart_mid);
        int base_res;
        int base_done;
        int err_before;
        int cycles;
        base_res = result_cnt;
        base_done = done_cnt;
        err_before = err_cnt;
        build_expected();
        @(negedge clk);
        started = 1'b1;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (restart_mid)
        begin
            repeat (100) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        cycles = 0;
        while (result_cnt < base_res + n_results && cycles < run_timeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (result_cnt < base_res + n_results)
        begin
            err_cnt++;
            $display("timed out with %0d of %0d results", result_cnt - base_res, n_results);
            exp_q.delete();
        end
        // a second run from the ignored start would show up here
        if (restart_mid)
            repeat (200) @(negedge clk);
        assert (result_cnt - base_res == n_results)
        else
        begin
            err_cnt++;
            $display("got %0d results instead of %0d", result_cnt - base_res, n_results);
        end
        assert (done_cnt - base_done == 1)
        else
        begin
            err_cnt++;
            $display("done pulsed %0d times in one run", done_cnt - base_done);
        end
        report_test(name, err_before);
    endtask

    initial
    begin
        int err_before;
        void'($urandom(32'h5de1));
        rst = 1'b1;
        host_wr = '0;
        host_wr_valid = 1'b0;
        start = 1'b0;
        started = 1'b0;
        result_cnt = 0;
        done_cnt = 0;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        err_before = err_cnt;
        repeat (50) @(negedge clk);
        report_test("idle after reset", err_before);

        load_layer(-32, 31, -8, 7, -256, 255);
        run_layer("random small values", 1'b0);

        load_layer(-32, 31, -8, 7, -32768, -32768);
        run_layer("negative bias gives zero", 1'b0);

        load_layer(500, 1000, 50, 100, 0, 0);
        run_layer("large values clip", 1'b0);

        run_layer("start while busy is ignored", 1'b1);

        load_layer(-100, 100, -20, 20, -1000, 1000);
        run_layer("reload between runs", 1'b0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
hw/conv_pkg.sv
hw/feature_bank.sv
hw/channel_mac.sv
hw/window_sequencer.sv
hw/sum_relu.sv
hw/conv_layer_top.sv
test/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv_layer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/conv_pkg.sv
      - hw/feature_bank.sv
      - hw/channel_mac.sv
      - hw/window_sequencer.sv
      - hw/sum_relu.sv
      - hw/conv_layer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/conv_tb.sv
